/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_noc_axi_subsystem
FLIST     = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/noc_trace.txt */
# op addr wdata resp rdata, all hex
# op W write, R read, B write and read offered in one cycle
R 0004 00000000 0 00000000
R 4008 00000000 0 00000000
R 003c 00000000 0 00000000
W 0010 a5a51234 0 00000000
R 0010 00000000 0 a5a51234
W 4010 5a5a8765 0 00000000
R 0010 00000000 0 a5a51234
R 4010 00000000 0 5a5a8765
W 8010 deadbeef 3 00000000
R c010 00000000 3 00000000
W c010 0badf00d 3 00000000
R 8010 00000000 3 00000000
R 0010 00000000 0 a5a51234
R 4010 00000000 0 5a5a8765
B 0020 13572468 0 13572468
B 4020 24681357 0 24681357
R 0020 00000000 0 13572468
W 003c ffffffff 0 00000000
W 0000 00000001 0 00000000
R 003c 00000000 0 ffffffff
R 0000 00000000 0 00000001
B 7ffc cafef00d 0 cafef00d
R 403c 00000000 0 cafef00d
B 8020 11112222 3 00000000

/* bench/tb_noc_axi_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module tb_noc_axi_subsystem;
  import noc_pkg::*;

  typedef struct packed {
    logic [7:0]             op;    // ascii W, R or B.
    logic [`NOC_ADDR_W-1:0] addr;
    logic [`NOC_DATA_W-1:0] wdata;
    logic [1:0]             resp;
    logic [`NOC_DATA_W-1:0] rdata; // expected read data.
  } trace_entry_t;

  logic         clk;
  logic         rst_n;
  logic         aw_valid;
  logic         aw_ready;
  axi_aw_t      aw;
  logic         w_valid;
  logic         w_ready;
  axi_w_t       w;
  logic         b_valid;
  logic         b_ready;
  axi_b_t       b;
  logic         ar_valid;
  logic         ar_ready;
  axi_ar_t      ar;
  logic         r_valid;
  logic         r_ready;
  axi_r_t       r;
  trace_entry_t trace_q[$];
  int           seed = 90418;
  int           limit = 0;
  int           cycles = 0;

  noc_axi_subsystem_top i_noc_axi_subsystem_top (
    .i_clk      (clk     ),
    .i_rst_n    (rst_n   ),
    .i_aw_valid (aw_valid),
    .o_aw_ready (aw_ready),
    .i_aw       (aw      ),
    .i_w_valid  (w_valid ),
    .o_w_ready  (w_ready ),
    .i_w        (w       ),
    .o_b_valid  (b_valid ),
    .i_b_ready  (b_ready ),
    .o_b        (b       ),
    .i_ar_valid (ar_valid),
    .o_ar_ready (ar_ready),
    .i_ar       (ar      ),
    .o_r_valid  (r_valid ),
    .i_r_ready  (r_ready ),
    .o_r        (r       )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic load_trace;
    int                     fd;
    int                     n;
    logic [7:0]             op;
    logic [1023:0]          rest;
    logic [`NOC_ADDR_W-1:0] addr;
    logic [`NOC_DATA_W-1:0] wdata;
    logic [1:0]             resp;
    logic [`NOC_DATA_W-1:0] rdata;
    trace_entry_t           e;
    fd = $fopen("bench/noc_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file bench/noc_trace.txt");
      $display("ERRORS FOUND");
      $fatal(1, "no trace");
    end
    n = $fscanf(fd, " %c", op);
    while (n == 1) begin
      if (op == "#") begin
        n = $fgets(rest, fd); // comment line.
      end else begin
        n = $fscanf(fd, "%h %h %h %h", addr, wdata, resp, rdata);
        if (n != 4) begin
          $display("trace line %0d is malformed", trace_q.size() + 1);
          $display("ERRORS FOUND");
          $fatal(1, "bad trace");
        end
        e = {op, addr, wdata, resp, rdata};
        trace_q.push_back(e);
      end
      n = $fscanf(fd, " %c", op);
    end
    $fclose(fd);
  endtask

  // readies are sampled on the falling edge.
  task automatic wait_accept(input logic is_write);
    @(negedge clk);
    while (!(is_write ? (aw_ready && w_ready) : ar_ready)) @(negedge clk);
    if (is_write) check_value("read taken beside a write", 64'(ar_ready), 64'(0));
    @(posedge clk);
    #1;
    if (is_write) begin
      aw_valid = 1'b0;
      w_valid  = 1'b0;
    end else begin
      ar_valid = 1'b0;
    end
  endtask

  task automatic hold_check(input logic is_write, input logic [63:0] first);
    check_value("response valid dropped", 64'(is_write ? b_valid : r_valid), 64'(1));
    check_value("response changed while held", is_write ? 64'(b) : 64'(r), first);
    check_value("request ready while response pending",
                64'({aw_ready, w_ready, ar_ready}), 64'(0));
  endtask

  task automatic collect_response(input logic is_write, input trace_entry_t e);
    int          delay;
    int          lat;
    logic        probe;
    logic [63:0] first;
    delay = {$random(seed)} % 4;
    lat   = 0;
    probe = !ar_valid; // spare request unless a read is pending.
    @(negedge clk);
    lat++;
    while (!(is_write ? b_valid : r_valid)) begin
      @(negedge clk);
      lat++;
    end
    if (e.resp == 2'd3) check_value("decode error latency", 64'(lat), 64'(2));
    first = is_write ? 64'(b) : 64'(r);
    @(posedge clk);
    #1;
    if (probe) begin
      if (is_write) begin
        ar.addr  = '0;
        ar_valid = 1'b1;
      end else begin
        aw_valid = 1'b1; // a write offered while the read is held.
        w_valid  = 1'b1;
      end
    end
    repeat (delay) begin
      @(negedge clk);
      hold_check(is_write, first);
      @(posedge clk);
      #1;
    end
    if (is_write) b_ready = 1'b1;
    else r_ready = 1'b1;
    @(negedge clk);
    hold_check(is_write, first);
    check_value("response code", 64'(is_write ? b.resp : r.resp), 64'(e.resp));
    if (!is_write) check_value("read data", 64'(r.data), 64'(e.rdata));
    @(posedge clk);
    #1;
    b_ready = 1'b0;
    r_ready = 1'b0;
    if (probe) begin
      aw_valid = 1'b0;
      w_valid  = 1'b0;
      ar_valid = 1'b0;
    end
  endtask

  task automatic run_entry(input trace_entry_t e);
    aw.addr = e.addr;
    w.data  = e.wdata;
    ar.addr = e.addr;
    case (e.op)
      "W": begin
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        wait_accept(1'b1);
        collect_response(1'b1, e);
      end
      "R": begin
        ar_valid = 1'b1;
        wait_accept(1'b0);
        collect_response(1'b0, e);
      end
      "B": begin
        aw_valid = 1'b1; // write and read in the same cycle.
        w_valid  = 1'b1;
        ar_valid = 1'b1;
        wait_accept(1'b1);
        collect_response(1'b1, e);
        wait_accept(1'b0);
        collect_response(1'b0, e);
      end
      default: begin
        $display("unknown operation '%c' in the trace", e.op);
        $display("ERRORS FOUND");
        $fatal(1, "bad op");
      end
    endcase
  endtask

  initial begin
    wait (limit > 0);
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= limit) begin
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
      end
    end
  end

  initial begin
    rst_n    = 1'b0;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    ar_valid = 1'b0;
    ar       = '0;
    b_ready  = 1'b0;
    r_ready  = 1'b0;
    load_trace();
    limit = trace_q.size() * 40 + 20;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("valid after reset", 64'({b_valid, r_valid}), 64'(0));
    @(posedge clk);
    #1;
    foreach (trace_q[i]) run_entry(trace_q[i]);
    $display("NO ERRORS");
    $finish;
  end
endmodule

`default_nettype wire

/* source/noc_address_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module noc_address_decoder (
  input  logic [`NOC_ADDR_W-1:0] i_addr,
  output noc_pkg::noc_decode_t   o_decode
);
  import noc_pkg::*;

  // top two address bits pick the node.
  always_comb begin
    o_decode = '0;
    case (i_addr[`NOC_ADDR_W-1 -: 2])
      2'd0: begin
        o_decode.id = noc_node_t'(1);
      end
      2'd1: begin
        o_decode.id = noc_node_t'(2);
      end
      default: begin
        o_decode.decode_error = 1'b1; // no node behind codes 2 and 3.
      end
    endcase
  end
endmodule

`default_nettype wire

/* source/noc_axi_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module noc_axi_subsystem_top (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_aw_valid,
  output logic             o_aw_ready,
  input  noc_pkg::axi_aw_t i_aw,
  input  logic             i_w_valid,
  output logic             o_w_ready,
  input  noc_pkg::axi_w_t  i_w,
  output logic             o_b_valid,
  input  logic             i_b_ready,
  output noc_pkg::axi_b_t  o_b,
  input  logic             i_ar_valid,
  output logic             o_ar_ready,
  input  noc_pkg::axi_ar_t i_ar,
  output logic             o_r_valid,
  input  logic             i_r_ready,
  output noc_pkg::axi_r_t  o_r
);
  import noc_pkg::*;

  logic [`NOC_ADDR_W-1:0] dec_addr;
  noc_decode_t            decode;
  logic                   req_valid;
  logic                   req_ready;
  noc_req_flit_t          req;
  logic                   rsp_valid;
  logic                   rsp_ready;
  noc_rsp_flit_t          rsp;
  logic                   req1_valid;
  logic                   req1_ready;
  noc_req_flit_t          req1;
  logic                   req2_valid;
  logic                   req2_ready;
  noc_req_flit_t          req2;
  logic                   rsp1_valid;
  logic                   rsp1_ready;
  noc_rsp_flit_t          rsp1;
  logic                   rsp2_valid;
  logic                   rsp2_ready;
  noc_rsp_flit_t          rsp2;

  noc_address_decoder u_decoder (
    .i_addr   (dec_addr),
    .o_decode (decode  )
  );

  noc_slave_adapter_fsm u_adapter (
    .i_clk       (i_clk     ),
    .i_rst_n     (i_rst_n   ),
    .i_aw_valid  (i_aw_valid),
    .i_aw        (i_aw      ),
    .i_w_valid   (i_w_valid ),
    .i_w         (i_w       ),
    .i_ar_valid  (i_ar_valid),
    .i_ar        (i_ar      ),
    .i_b_ready   (i_b_ready ),
    .i_r_ready   (i_r_ready ),
    .o_aw_ready  (o_aw_ready),
    .o_w_ready   (o_w_ready ),
    .o_ar_ready  (o_ar_ready),
    .o_b_valid   (o_b_valid ),
    .o_b         (o_b       ),
    .o_r_valid   (o_r_valid ),
    .o_r         (o_r       ),
    .o_dec_addr  (dec_addr  ),
    .i_decode    (decode    ),
    .o_req_valid (req_valid ),
    .o_req       (req       ),
    .i_req_ready (req_ready ),
    .i_rsp_valid (rsp_valid ),
    .i_rsp       (rsp       ),
    .o_rsp_ready (rsp_ready )
  );

  noc_router u_router (
    .i_req_valid  (req_valid ),
    .i_req        (req       ),
    .o_req_ready  (req_ready ),
    .o_req1_valid (req1_valid),
    .o_req1       (req1      ),
    .i_req1_ready (req1_ready),
    .o_req2_valid (req2_valid),
    .o_req2       (req2      ),
    .i_req2_ready (req2_ready),
    .i_rsp1_valid (rsp1_valid),
    .i_rsp1       (rsp1      ),
    .o_rsp1_ready (rsp1_ready),
    .i_rsp2_valid (rsp2_valid),
    .i_rsp2       (rsp2      ),
    .o_rsp2_ready (rsp2_ready),
    .o_rsp_valid  (rsp_valid ),
    .o_rsp        (rsp       ),
    .i_rsp_ready  (rsp_ready )
  );

  noc_memory_endpoint #(
    .NODE_ID (noc_node_t'(1))
  ) u_endpoint1 (
    .i_clk       (i_clk     ),
    .i_rst_n     (i_rst_n   ),
    .i_req_valid (req1_valid),
    .i_req       (req1      ),
    .o_req_ready (req1_ready),
    .o_rsp_valid (rsp1_valid),
    .o_rsp       (rsp1      ),
    .i_rsp_ready (rsp1_ready)
  );

  noc_memory_endpoint #(
    .NODE_ID (noc_node_t'(2))
  ) u_endpoint2 (
    .i_clk       (i_clk     ),
    .i_rst_n     (i_rst_n   ),
    .i_req_valid (req2_valid),
    .i_req       (req2      ),
    .o_req_ready (req2_ready),
    .o_rsp_valid (rsp2_valid),
    .o_rsp       (rsp2      ),
    .i_rsp_ready (rsp2_ready)
  );
endmodule

`default_nettype wire

/* source/noc_flit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module noc_flit_fifo #(
  parameter type flit_t = noc_pkg::noc_req_flit_t
)(
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_push,
  input  flit_t i_data,
  output logic  o_full,
  input  logic  i_pop,
  output flit_t o_data,
  output logic  o_empty
);
  localparam int DEPTH = `NOC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign o_full  = count == CNT_W'(DEPTH);
  assign o_empty = count == '0;
  assign o_data  = mem[rd_ptr]; // head shows without a pop.

  always_ff @(posedge i_clk) begin
    if (i_push) mem[wr_ptr] <= i_data;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (i_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (i_push && !i_pop) begin
        count <= count + 1'b1;
      end else if (i_pop && !i_push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_no_overrun: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_push && o_full) && !(i_pop && o_empty));
endmodule

`default_nettype wire

/* source/noc_memory_endpoint.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module noc_memory_endpoint #(
  parameter noc_pkg::noc_node_t NODE_ID = noc_pkg::noc_node_t'(1)
)(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_req_valid,
  input  noc_pkg::noc_req_flit_t i_req,
  output logic                   o_req_ready,
  output logic                   o_rsp_valid,
  output noc_pkg::noc_rsp_flit_t o_rsp,
  input  logic                   i_rsp_ready
);
  import noc_pkg::*;

  localparam int WORDS = 16;

  logic [`NOC_DATA_W-1:0] mem [WORDS];
  noc_req_flit_t          head;
  noc_req_flit_t          cur;
  logic                   req_full;
  logic                   req_empty;
  logic                   busy;
  logic                   pop;
  logic                   timer_done;

  assign o_req_ready = !req_full;
  assign pop         = !busy && !req_empty; // one request in service at a time.

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      busy        <= 1'b0;
      o_rsp_valid <= 1'b0;
    end else begin
      if (pop) begin
        busy <= 1'b1;
      end else if (o_rsp_valid && i_rsp_ready) begin
        busy <= 1'b0;
      end
      if (timer_done) begin
        o_rsp_valid <= 1'b1;
      end else if (i_rsp_ready) begin
        o_rsp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < WORDS; i++) mem[i] <= '0;
    end else if (timer_done && cur.is_write) begin
      mem[cur.word] <= cur.wdata;
    end
  end

  always_ff @(posedge i_clk) begin
    if (pop) cur <= head;
    if (timer_done) begin
      o_rsp.dst      <= cur.src;   // back to the requester.
      o_rsp.src      <= NODE_ID;
      o_rsp.is_write <= cur.is_write;
      o_rsp.rdata    <= cur.is_write ? '0 : mem[cur.word];
      o_rsp.resp     <= OKAY;
    end
  end

  noc_flit_fifo #(
    .flit_t (noc_req_flit_t)
  ) u_req_fifo (
    .i_clk   (i_clk                     ),
    .i_rst_n (i_rst_n                   ),
    .i_push  (i_req_valid && !req_full  ),
    .i_data  (i_req                     ),
    .o_full  (req_full                  ),
    .i_pop   (pop                       ),
    .o_data  (head                      ),
    .o_empty (req_empty                 )
  );

  noc_wait_timer u_wait_timer (
    .i_clk   (i_clk     ),
    .i_rst_n (i_rst_n   ),
    .i_start (pop       ),
    .o_done  (timer_done)
  );
endmodule

`default_nettype wire

/* source/noc_pkg.sv */
`default_nettype none

`include "noc_settings.svh"

package noc_pkg;
  typedef logic [1:0] noc_node_t; // 0 is the adapter.

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } axi_resp_t;

  typedef struct packed {
    logic [`NOC_ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [`NOC_ADDR_W-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [`NOC_DATA_W-1:0] data;
  } axi_w_t;

  typedef struct packed {
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    logic [`NOC_DATA_W-1:0] data;
    axi_resp_t              resp;
  } axi_r_t;

  typedef struct packed {
    noc_node_t              dst;
    noc_node_t              src;
    logic                   is_write;
    logic [3:0]             word;   // address bits 5:2.
    logic [`NOC_DATA_W-1:0] wdata;
  } noc_req_flit_t;

  typedef struct packed {
    noc_node_t              dst;
    noc_node_t              src;
    logic                   is_write;
    logic [`NOC_DATA_W-1:0] rdata;
    axi_resp_t              resp;
  } noc_rsp_flit_t;

  typedef struct packed {
    noc_node_t id;
    logic      decode_error;
  } noc_decode_t;
endpackage

`default_nettype wire

/* source/noc_router.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_router (
  input  logic                   i_req_valid,
  input  noc_pkg::noc_req_flit_t i_req,
  output logic                   o_req_ready,
  output logic                   o_req1_valid,
  output noc_pkg::noc_req_flit_t o_req1,
  input  logic                   i_req1_ready,
  output logic                   o_req2_valid,
  output noc_pkg::noc_req_flit_t o_req2,
  input  logic                   i_req2_ready,
  input  logic                   i_rsp1_valid,
  input  noc_pkg::noc_rsp_flit_t i_rsp1,
  output logic                   o_rsp1_ready,
  input  logic                   i_rsp2_valid,
  input  noc_pkg::noc_rsp_flit_t i_rsp2,
  output logic                   o_rsp2_ready,
  output logic                   o_rsp_valid,
  output noc_pkg::noc_rsp_flit_t o_rsp,
  input  logic                   i_rsp_ready
);
  import noc_pkg::*;

  logic to_node1;
  logic to_node2;

  assign to_node1     = i_req.dst == noc_node_t'(1);
  assign to_node2     = i_req.dst == noc_node_t'(2);
  assign o_req1_valid = i_req_valid && to_node1;
  assign o_req2_valid = i_req_valid && to_node2;
  assign o_req1       = i_req;
  assign o_req2       = i_req;
  assign o_req_ready  = (to_node1 && i_req1_ready) || (to_node2 && i_req2_ready);

  // endpoint 1 wins when both answer.
  assign o_rsp_valid  = i_rsp1_valid || i_rsp2_valid;
  assign o_rsp        = i_rsp1_valid ? i_rsp1 : i_rsp2;
  assign o_rsp1_ready = i_rsp_ready;
  assign o_rsp2_ready = i_rsp_ready && !i_rsp1_valid;

  always_comb begin
    if (i_req_valid) begin
      a_dst_valid: assert (to_node1 || to_node2)
        else $error("request flit to unrouted node %0d", i_req.dst);
    end
  end
endmodule

`default_nettype wire

/* source/noc_settings.svh */
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// axi-lite address and data widths.
`define NOC_ADDR_W 16
`define NOC_DATA_W 32

// flit fifo entries.
`define NOC_FIFO_DEPTH 2

// cycles an endpoint waits before it answers.
`define NOC_ENDPOINT_WAIT 3

`endif

/* source/noc_slave_adapter_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module noc_slave_adapter_fsm (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_aw_valid,
  input  noc_pkg::axi_aw_t       i_aw,
  input  logic                   i_w_valid,
  input  noc_pkg::axi_w_t        i_w,
  input  logic                   i_ar_valid,
  input  noc_pkg::axi_ar_t       i_ar,
  input  logic                   i_b_ready,
  input  logic                   i_r_ready,
  output logic                   o_aw_ready,
  output logic                   o_w_ready,
  output logic                   o_ar_ready,
  output logic                   o_b_valid,
  output noc_pkg::axi_b_t        o_b,
  output logic                   o_r_valid,
  output noc_pkg::axi_r_t        o_r,
  output logic [`NOC_ADDR_W-1:0] o_dec_addr,
  input  noc_pkg::noc_decode_t   i_decode,
  output logic                   o_req_valid,
  output noc_pkg::noc_req_flit_t o_req,
  input  logic                   i_req_ready,
  input  logic                   i_rsp_valid,
  input  noc_pkg::noc_rsp_flit_t i_rsp,
  output logic                   o_rsp_ready
);
  import noc_pkg::*;

  localparam noc_node_t ADAPTER_NODE = noc_node_t'(0);

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT,
    RESP
  } state_t;

  state_t        state;
  state_t        state_next;
  logic          take_write;
  logic          take_read;
  logic          dec_err_q;
  logic          rsp_full;
  logic          rsp_empty;
  logic          rsp_pop;
  noc_rsp_flit_t rsp_head;

  assign take_write  = (state == IDLE) && i_aw_valid && i_w_valid; // write wins.
  assign take_read   = (state == IDLE) && i_ar_valid && !(i_aw_valid && i_w_valid);
  assign o_aw_ready  = take_write;
  assign o_w_ready   = take_write;
  assign o_ar_ready  = take_read;
  assign o_dec_addr  = (i_aw_valid && i_w_valid) ? i_aw.addr : i_ar.addr;
  assign o_req_valid = (state == SEND) && !dec_err_q;
  assign rsp_pop     = (state == WAIT) && !rsp_empty;
  assign o_rsp_ready = !rsp_full;
  assign o_b_valid   = (state == RESP) && o_req.is_write;
  assign o_r_valid   = (state == RESP) && !o_req.is_write;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (take_write || take_read) state_next = SEND;
      SEND: begin
        if (dec_err_q) begin
          state_next = RESP; // answered here, no flit.
        end else if (i_req_ready) begin
          state_next = WAIT;
        end
      end
      WAIT: if (!rsp_empty) state_next = RESP;
      RESP: if ((o_b_valid && i_b_ready) || (o_r_valid && i_r_ready)) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take_write || take_read) begin
      o_req.dst      <= i_decode.id;
      o_req.src      <= ADAPTER_NODE;
      o_req.is_write <= take_write;
      o_req.word     <= o_dec_addr[5:2];
      o_req.wdata    <= i_w.data;
      dec_err_q      <= i_decode.decode_error;
    end
    if ((state == SEND) && dec_err_q) begin
      o_b.resp <= DECERR;
      o_r.data <= '0;
      o_r.resp <= DECERR;
    end else if (rsp_pop) begin
      o_b.resp <= rsp_head.resp;
      o_r.data <= rsp_head.rdata;
      o_r.resp <= rsp_head.resp;
    end
  end

  noc_flit_fifo #(
    .flit_t (noc_rsp_flit_t)
  ) u_rsp_fifo (
    .i_clk   (i_clk                     ),
    .i_rst_n (i_rst_n                   ),
    .i_push  (i_rsp_valid && !rsp_full  ),
    .i_data  (i_rsp                     ),
    .o_full  (rsp_full                  ),
    .i_pop   (rsp_pop                   ),
    .o_data  (rsp_head                  ),
    .o_empty (rsp_empty                 )
  );

  a_req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_req_valid && !i_req_ready |=> o_req_valid && $stable(o_req));

  // the single outstanding request is the only one a response can belong to.
  a_rsp_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    rsp_pop |-> (rsp_head.dst == ADAPTER_NODE) && (rsp_head.src == o_req.dst)
                && (rsp_head.is_write == o_req.is_write));
endmodule

`default_nettype wire

/* source/noc_wait_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module noc_wait_timer (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_start,
  output logic o_done
);
  localparam int WAIT  = `NOC_ENDPOINT_WAIT;
  localparam int CNT_W = $clog2(WAIT + 1);

  logic [CNT_W-1:0] count;

  assign o_done = count == CNT_W'(1); // last wait cycle.

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      count <= '0;
    end else if (i_start) begin
      count <= CNT_W'(WAIT);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  a_start_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_start |-> (count == '0));
endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/noc_pkg.sv
source/noc_address_decoder.sv
source/noc_flit_fifo.sv
source/noc_wait_timer.sv
source/noc_memory_endpoint.sv
source/noc_router.sv
source/noc_slave_adapter_fsm.sv
source/noc_axi_subsystem_top.sv
bench/tb_noc_axi_subsystem.sv
